/* rtl/sram_pkg.sv */
`default_nettype none

package sram_pkg;

  // Word and byte lane geometry
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned LANE_W    = 8;
  localparam int unsigned NUM_LANES = DATA_W / LANE_W;

  // Write data, read data and response words
  typedef logic [DATA_W-1:0] data_t;

  // Byte strobe, one bit per lane
  typedef logic [NUM_LANES-1:0] strb_t;

endpackage

`default_nettype wire

/* rtl/spsram_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

module spsram_wrapper
  import sram_pkg::*;
#(
  parameter int unsigned DATA_DEPTH = 256,
  parameter int unsigned BYTE_SIZE  = 8
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n_i,
  input  wire logic [$clog2(DATA_DEPTH)-1:0] addr_i,
  input  wire logic                          en_i,
  input  wire strb_t                         we_i,
  input  wire data_t                         wdata_i,
  output data_t                              rdata_o
);

  localparam int unsigned LANES = DATA_W / BYTE_SIZE;

  data_t mem [DATA_DEPTH];

  // Array write, per byte lane
  always_ff @(posedge clk) begin
    if (en_i) begin
      for (int i = 0; i < LANES; i++) begin
        if (we_i[i]) begin
          mem[addr_i][i*BYTE_SIZE +: BYTE_SIZE] <= wdata_i[i*BYTE_SIZE +: BYTE_SIZE];
        end
      end
    end
  end

  // Registered read port, write-first per lane
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_o <= '0;
    end else if (en_i) begin
      for (int i = 0; i < LANES; i++) begin
        if (we_i[i]) begin
          rdata_o[i*BYTE_SIZE +: BYTE_SIZE] <= wdata_i[i*BYTE_SIZE +: BYTE_SIZE]; // New byte
        end else begin
          rdata_o[i*BYTE_SIZE +: BYTE_SIZE] <= mem[addr_i][i*BYTE_SIZE +: BYTE_SIZE];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/sram_access_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_access_ctrl
  import sram_pkg::*;
#(
  parameter int unsigned DATA_DEPTH = 256,
  parameter int unsigned CREDITS    = 4
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n_i,
  // Request side
  input  wire logic                          req_valid_i,
  input  wire logic                          req_write_i,
  input  wire logic [$clog2(DATA_DEPTH)-1:0] req_addr_i,
  input  wire strb_t                         req_strb_i,
  input  wire data_t                         req_wdata_i,
  // Credit returned by the response buffer
  input  wire logic                          pop_credit_i,
  // SRAM port
  output logic                               sram_en_o,
  output strb_t                              sram_we_o,
  output logic [$clog2(DATA_DEPTH)-1:0]      sram_addr_o,
  output data_t                              sram_wdata_o,
  // To response buffer
  output logic                               push_o,
  output logic                               credit_err_o
);

  localparam int unsigned CNT_W = $clog2(CREDITS + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CREDITS);

  logic [CNT_W-1:0] credit_cnt_q;
  logic [CNT_W-1:0] credit_cnt_d;
  logic             no_credit;
  logic             violation;

  // SRAM driven straight from the request
  assign sram_en_o    = req_valid_i;
  assign sram_we_o    = req_write_i ? req_strb_i : '0; // Zero lanes on reads
  assign sram_addr_o  = req_addr_i;
  assign sram_wdata_o = req_wdata_i;

  assign no_credit = (credit_cnt_q == '0);
  assign violation = req_valid_i && no_credit;

  // Mirror of the requester's credits saturates both ways
  always_comb begin
    credit_cnt_d = credit_cnt_q;
    if (req_valid_i && !no_credit) begin
      credit_cnt_d = credit_cnt_d - CNT_W'(1);
    end
    if (pop_credit_i && (credit_cnt_d != CNT_MAX)) begin
      credit_cnt_d = credit_cnt_d + CNT_W'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_cnt_q <= CNT_MAX; // Full credit after reset
    end else begin
      credit_cnt_q <= credit_cnt_d;
    end
  end

  // Push lines up with read data one cycle after the SRAM edge
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      push_o <= 1'b0;
    end else begin
      push_o <= sram_en_o;
    end
  end

  // Sticky until reset
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_err_o <= 1'b0;
    end else if (violation) begin
      credit_err_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/sram_resp_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_resp_fifo
  import sram_pkg::*;
#(
  parameter int unsigned CREDITS = 4
) (
  input  wire logic  clk,
  input  wire logic  rst_n_i,
  // Write side from the SRAM read port
  input  wire logic  push_i,
  input  wire data_t push_data_i,
  // Response side
  input  wire logic  resp_ready_i,
  output logic       resp_valid_o,
  output data_t      resp_data_o,
  // One pulse per entry popped
  output logic       credit_o
);

  localparam int unsigned PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
  localparam int unsigned CNT_W = $clog2(CREDITS + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(CREDITS - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(CREDITS);

  data_t            buf_mem [CREDITS];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             wr_en;
  logic             pop;

  assign full  = (count_q == CNT_FULL);
  assign wr_en = push_i && !full; // Credit rule keeps this from dropping
  assign pop   = resp_valid_o && resp_ready_i;

  // Show-ahead output
  assign resp_valid_o = (count_q != '0);
  assign resp_data_o  = buf_mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      buf_mem[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap at CREDITS even when it is not a power of two
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + PTR_W'(1);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      case ({wr_en, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q; // Idle or push and pop together
      endcase
    end
  end

  // Credit pulse in the cycle after a pop
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop;
    end
  end

endmodule

`default_nettype wire

/* rtl/sram_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_subsys_top
  import sram_pkg::*;
#(
  parameter int unsigned DATA_DEPTH = 256,
  parameter int unsigned CREDITS    = 4
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n_i,
  // Requests
  input  wire logic                          req_valid_i,
  input  wire logic                          req_write_i,
  input  wire logic [$clog2(DATA_DEPTH)-1:0] req_addr_i,
  input  wire strb_t                         req_strb_i,
  input  wire data_t                         req_wdata_i,
  // Credits
  output logic                               credit_o,
  output logic                               credit_err_o,
  // Responses
  output logic                               resp_valid_o,
  output data_t                              resp_data_o,
  input  wire logic                          resp_ready_i
);

  logic                          sram_en;
  strb_t                         sram_we;
  logic [$clog2(DATA_DEPTH)-1:0] sram_addr;
  data_t                         sram_wdata;
  data_t                         sram_rdata;
  logic                          push;
  logic                          pop_credit;

  assign credit_o = pop_credit; // Also feeds the controller's mirror

  sram_access_ctrl #(
    .DATA_DEPTH (DATA_DEPTH),
    .CREDITS    (CREDITS)
  ) u_ctrl (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_write_i  (req_write_i),
    .req_addr_i   (req_addr_i),
    .req_strb_i   (req_strb_i),
    .req_wdata_i  (req_wdata_i),
    .pop_credit_i (pop_credit),
    .sram_en_o    (sram_en),
    .sram_we_o    (sram_we),
    .sram_addr_o  (sram_addr),
    .sram_wdata_o (sram_wdata),
    .push_o       (push),
    .credit_err_o (credit_err_o)
  );

  spsram_wrapper #(
    .DATA_DEPTH (DATA_DEPTH),
    .BYTE_SIZE  (LANE_W)
  ) u_sram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .addr_i  (sram_addr),
    .en_i    (sram_en),
    .we_i    (sram_we),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  sram_resp_fifo #(
    .CREDITS (CREDITS)
  ) u_resp_fifo (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .push_i       (push),
    .push_data_i  (sram_rdata),
    .resp_ready_i (resp_ready_i),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o),
    .credit_o     (pop_credit)
  );

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS = 20
) (
  output logic clk_o
);

  initial clk_o = 1'b0; // Starts low

  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* tests/sram_subsys_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_subsys_assert
  import sram_pkg::*;
(
  input wire logic  clk,
  input wire logic  rst_n_i,
  input wire logic  push_i,
  input wire logic  full_i,
  input wire logic  credit_i,
  input wire logic  resp_valid_i,
  input wire logic  resp_ready_i,
  input wire data_t resp_data_i
);

  no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    push_i |-> !full_i)
    else $error("push into a full response buffer");

  // Pulse follows the response handshake by one cycle
  credit_after_pop: assert property (@(posedge clk) disable iff (!rst_n_i)
    credit_i == $past(resp_valid_i && resp_ready_i))
    else $error("credit pulse not in the cycle after a pop");

  // Head entry must not move while stalled
  data_held_when_stalled: assert property (@(posedge clk) disable iff (!rst_n_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_data_i))
    else $error("response changed while resp_ready_i was low");

  quiet_in_reset: assert property (@(posedge clk)
    !rst_n_i |-> !resp_valid_i && !credit_i)
    else $error("response outputs active during reset");

endmodule

bind sram_resp_fifo sram_subsys_assert u_assert (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .push_i       (push_i),
  .full_i       (full),
  .credit_i     (credit_o),
  .resp_valid_i (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .resp_data_i  (resp_data_o)
);

`default_nettype wire

/* tests/tb_sram_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sram_subsys
  import sram_pkg::*;
();

  localparam int unsigned DATA_DEPTH  = 256;
  localparam int unsigned CREDITS     = 4;
  localparam int unsigned AW          = $clog2(DATA_DEPTH);
  localparam int unsigned CLK_PERIOD  = 20;
  localparam int unsigned DRV         = 2; // Input skew after the rising edge
  localparam int unsigned N_RANDOM    = 400;
  localparam int unsigned N_REQ       = DATA_DEPTH + 5 + 4 * CREDITS + N_RANDOM + 2;
  localparam int unsigned WDOG_CYCLES = N_REQ * 20 + 500; // 20 cycles per request at worst

  typedef logic [AW-1:0] addr_t;

  logic  clk;
  logic  rst_n;
  logic  req_valid;
  logic  req_write;
  addr_t req_addr;
  strb_t req_strb;
  data_t req_wdata;
  logic  resp_ready;
  logic  resp_valid;
  data_t resp_data;
  logic  credit;
  logic  credit_err;

  data_t       ref_mem [DATA_DEPTH]; // Reference copy of the SRAM
  data_t       exp_q [$];
  logic [31:0] req_state    = 32'd72619;
  logic [31:0] rdy_state    = 32'd72619 ^ 32'h9e37_79b9;
  int          credits      = 0;
  int          pulses       = 0;
  int          req_count    = 0;
  int          resp_count   = 0;
  int          cycle        = 0;
  int          accept_edge  = 0;
  bit          rdy_random   = 1'b0;
  bit          err_check_en = 1'b1;
  bit          err_level    = 1'b0;
  bit          run_done     = 1'b0;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk_gen (.clk_o(clk));

  sram_subsys_top #(
    .DATA_DEPTH (DATA_DEPTH),
    .CREDITS    (CREDITS)
  ) UUT (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .req_valid_i  (req_valid),
    .req_write_i  (req_write),
    .req_addr_i   (req_addr),
    .req_strb_i   (req_strb),
    .req_wdata_i  (req_wdata),
    .credit_o     (credit),
    .credit_err_o (credit_err),
    .resp_valid_o (resp_valid),
    .resp_data_o  (resp_data),
    .resp_ready_i (resp_ready)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Applies one request to the reference copy and returns the expected response word
  function automatic data_t ref_apply(input logic wr, input addr_t addr, input strb_t strb,
                                      input data_t wdata);
    data_t word;
    word = ref_mem[addr];
    if (wr) begin
      for (int b = 0; b < NUM_LANES; b++) begin
        if (strb[b]) word[b*LANE_W +: LANE_W] = wdata[b*LANE_W +: LANE_W];
      end
      ref_mem[addr] = word;
    end
    return word;
  endfunction

  task automatic fail_now(input string msg);
    run_done = 1'b1;
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) fail_now($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic expect_count(input string name, input int got, input int exp);
    if (got != exp) fail_now($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic apply_reset();
    #DRV;
    rst_n   = 1'b0;
    credits = CREDITS;
    repeat (2) @(posedge clk);
    #DRV;
    rst_n = 1'b1;
  endtask

  task automatic idle_bus();
    @(posedge clk);
    #DRV;
    req_valid = 1'b0;
  endtask

  // Waits for a credit unless told to break the rule
  task automatic send_req(input logic wr, input addr_t addr, input strb_t strb,
                          input data_t wdata, input bit ignore_credit);
    @(posedge clk);
    #DRV;
    while (credits <= 0 && !ignore_credit) begin
      req_valid = 1'b0;
      @(posedge clk);
      #DRV;
    end
    req_valid   = 1'b1;
    req_write   = wr;
    req_addr    = addr;
    req_strb    = strb;
    req_wdata   = wdata;
    credits     = credits - 1;
    req_count   = req_count + 1;
    accept_edge = cycle + 1;
    exp_q.push_back(ref_apply(wr, addr, strb, wdata));
  endtask

  task automatic send_random(input bit ignore_credit);
    logic [31:0] r;
    req_state = xorshift32(req_state);
    r = req_state;
    req_state = xorshift32(req_state);
    send_req(r[0], addr_t'(r >> 8), strb_t'(r >> 4), req_state, ignore_credit);
  endtask

  // Ends on a rising edge with every response taken and every credit back
  task automatic drain();
    idle_bus();
    resp_ready = 1'b1;
    do @(posedge clk); while (exp_q.size() != 0 || credits != CREDITS);
  endtask

  task automatic fill_memory();
    for (int a = 0; a < DATA_DEPTH; a++) begin
      req_state = xorshift32(req_state);
      send_req(1'b1, addr_t'(a), '1, req_state, 1'b0);
    end
    drain();
  endtask

  task automatic write_read_merge();
    send_req(1'b1, addr_t'(33), '1, 32'hcafe_f00d, 1'b0);
    send_req(1'b0, addr_t'(33), '0, '0, 1'b0);
    send_req(1'b1, addr_t'(77), 4'b0101, 32'h1122_3344, 1'b0); // Lanes 0 and 2 only
    send_req(1'b1, addr_t'(77), 4'b1000, 32'haabb_ccdd, 1'b0);
    send_req(1'b0, addr_t'(77), '0, '0, 1'b0);
    drain();
  endtask

  task automatic back_to_back();
    int acc;
    int first;
    send_req(1'b0, addr_t'(3), '0, '0, 1'b0);
    acc = accept_edge - 1; // Edge the request went out after
    idle_bus();
    while (!resp_valid) @(negedge clk);
    expect_count("resp_valid_o latency", cycle - acc, 2);
    drain();
    for (int i = 0; i < 2 * CREDITS; i++) begin
      send_random(1'b0);
      if (i == 0) first = accept_edge;
    end
    // Credits return in time to keep one request per cycle
    expect_count("back-to-back accepts", accept_edge - first, 2 * CREDITS - 1);
    drain();
  endtask

  task automatic backpressure();
    int p0;
    idle_bus();
    resp_ready = 1'b0;
    p0 = pulses;
    repeat (CREDITS) send_random(1'b0);
    idle_bus();
    repeat (4) @(posedge clk);
    expect_count("credit_o pulses while stalled", pulses - p0, 0);
    drain();
    repeat (4) @(posedge clk);
    expect_count("credit_o pulses after drain", pulses - p0, CREDITS);
  endtask

  task automatic random_traffic();
    rdy_random = 1'b1;
    repeat (N_RANDOM) send_random(1'b0);
    @(negedge clk);
    rdy_random = 1'b0;
    drain();
    check_flag("credit_err_o", credit_err, 1'b0);
  endtask

  // One request beyond the credits, sent straight after reset
  task automatic credit_violation();
    err_check_en = 1'b0;
    apply_reset();
    resp_ready = 1'b0; // No credit comes back before the extra request
    repeat (CREDITS) send_random(1'b0);
    send_random(1'b1);
    resp_ready = 1'b1; // Head leaves as the extra request lands
    idle_bus();
    check_flag("credit_err_o", credit_err, 1'b1);
    err_level    = 1'b1;
    err_check_en = 1'b1;
    drain();
  endtask

  always @(posedge clk) cycle <= cycle + 1;

  always @(posedge clk) begin
    #DRV;
    if (rdy_random) begin
      rdy_state  = xorshift32(rdy_state);
      resp_ready = rdy_state[9];
    end
  end

  always @(negedge clk) begin
    if (rst_n && credit) begin
      credits = credits + 1;
      pulses  = pulses + 1;
    end
  end

  // Transfer happens at the coming rising edge
  always @(negedge clk) begin
    if (rst_n && resp_valid && resp_ready) begin
      if (exp_q.size() == 0) begin
        fail_now("response transfer with no request outstanding");
      end else begin
        check_data("resp_data_o", resp_data, exp_q.pop_front());
        resp_count = resp_count + 1;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && err_check_en) check_flag("credit_err_o", credit_err, err_level);
  end

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    fail_now($sformatf("watchdog expired after %0d cycles", WDOG_CYCLES));
  end

  final begin
    if (!run_done) begin
      $display("simulation stopped before the test sequence completed");
      $display("*** TEST FAILED ***");
    end
  end

  initial begin
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_addr   = '0;
    req_strb   = '0;
    req_wdata  = '0;
    resp_ready = 1'b1;
    apply_reset();
    fill_memory();
    write_read_merge();
    back_to_back();
    backpressure();
    random_traffic();
    credit_violation();
    if (exp_q.size() != 0 || resp_count != req_count) begin
      fail_now($sformatf("%0d requests sent but %0d responses received", req_count, resp_count));
    end else begin
      run_done = 1'b1;
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* build.f */
rtl/sram_pkg.sv
rtl/spsram_wrapper.sv
rtl/sram_access_ctrl.sv
rtl/sram_resp_fifo.sv
rtl/sram_subsys_top.sv
tests/tb_clk_gen.sv
tests/sram_subsys_assert.sv
tests/tb_sram_subsys.sv

/* Makefile */
# Verilator build and run for the SRAM access subsystem
VERILATOR ?= verilator
TOP       ?= tb_sram_subsys
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -j 0
FAIL_MSG  ?= *** TEST FAILED ***
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation incomplete, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
